// File: comb_nonspec_allocator.f
hdl/noc_alloc_pkg.sv
hdl/rr_arbiter.sv
hdl/ovc_candidate_select.sv
hdl/nonspec_sw_alloc.sv
hdl/ovc_grant_route.sv
hdl/comb_nonspec_allocator.sv
verification/comb_nonspec_allocator_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, then search the log for the fail message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f comb_nonspec_allocator.f \
    --top-module comb_nonspec_allocator_tb -o sim_tb \
    || { echo "build failed"; exit 1; }
./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "Result: FAILED" sim.log && exit 1
grep -q "Result: PASSED" sim.log || exit 1
exit 0

// File: verification/comb_nonspec_allocator_tb.sv
`timescale 1ns/10ps

module comb_nonspec_allocator_tb;

    import noc_alloc_pkg::*;

    localparam int EXT_P_EN = 1;
    localparam int N_RAND = 200;
    // reset, directed and random cycles at 4 ns each, plus margin
    localparam int TIMEOUT_NS = (10 + 40 + N_RAND) * 4 + 400;

    logic              clk = 1'b0;
    logic              rst;
    ivc_mask_t         ivc_request_all;
    ivc_mask_t         ovc_is_assigned_all;
    ivc_mask_t         assigned_ovc_not_full_all;
    ovc_req_all_t      masked_ovc_request_all;
    dest_port_all_t    dest_port_all;
    port_mask_t        iport_weight_is_consumed_all;
    granted_dest_all_t granted_dest_port_all;
    ivc_mask_t         ivc_num_getting_sw_grant;
    port_mask_t        any_ivc_sw_request_granted_all;
    port_mask_t        any_ovc_granted_in_outport_all;
    ivc_mask_t         ivc_num_getting_ovc_grant;
    ovc_req_all_t      granted_ovc_num_all;
    ivc_mask_t         ovc_allocated_all;

    // model copies of the arbiter pointers
    int in_ptr [NUM_PORT] = '{default: 0};
    int out_ptr [NUM_PORT] = '{default: 0};
    int ovc_ptr [NUM_IVC] = '{default: 0};
    logic [31:0] lcg_state = 32'h20d;

    comb_nonspec_allocator #(
        .FIRST_ARBITER_EXT_P_EN(EXT_P_EN)
    ) uut (.*);

    always #2 clk = ~clk;

    // first requester at or after the pointer, -1 when idle
    function automatic int rr_pick(input logic [3:0] req, input int ptr, input int width);
        int idx;
        for (int off = 0; off < width; off++) begin
            idx = (ptr + off) % width;
            if (req[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [79:0] got,
                               input logic [79:0] exp);
        assert (got === exp)
        else abort_run($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic clear_inputs();
        ivc_request_all = '0;
        ovc_is_assigned_all = '0;
        assigned_ovc_not_full_all = '0;
        masked_ovc_request_all = '0;
        dest_port_all = '0;
        iport_weight_is_consumed_all = '0;
    endtask

    // one ivc of port src heading for router port dst
    task automatic add_request(input int src, input int vc, input int dst,
                               input logic assigned, input logic not_full, input vc_mask_t mask);
        int n;
        n = src * NUM_VC + vc;
        ivc_request_all[n] = 1'b1;
        ovc_is_assigned_all[n] = assigned;
        assigned_ovc_not_full_all[n] = not_full;
        masked_ovc_request_all[n*NUM_VC +: NUM_VC] = mask;
        dest_port_all[n*NUM_PORT_M1 +: NUM_PORT_M1] =
            dest_port_t'(1) << ((dst < src) ? dst : dst - 1);
    endtask

    // predict from inputs and model pointers, compare, then move the pointers
    task automatic check_and_advance();
        granted_dest_all_t exp_gdest;
        ivc_mask_t exp_sw;
        ivc_mask_t exp_ovc;
        ovc_req_all_t exp_gnum;
        ivc_mask_t exp_alloc;
        port_mask_t exp_any_in;
        port_mask_t exp_any_out;
        ivc_mask_t req_m;
        dest_port_t first_dest [NUM_PORT];
        vc_mask_t cand_win [NUM_PORT];
        dest_port_t oreq;
        int in_win [NUM_PORT];
        int out_slot [NUM_PORT];
        int out_src [NUM_PORT];
        int cand [NUM_IVC];
        int n;
        int j;
        exp_gdest = '0;
        exp_sw = '0;
        exp_ovc = '0;
        exp_gnum = '0;
        exp_alloc = '0;
        exp_any_out = '0;
        // masked switch request and ovc candidate per ivc
        for (int k = 0; k < NUM_IVC; k++) begin
            req_m[k] = (ivc_request_all[k] & ovc_is_assigned_all[k] & assigned_ovc_not_full_all[k])
                | (|masked_ovc_request_all[k*NUM_VC +: NUM_VC]);
            cand[k] = rr_pick(masked_ovc_request_all[k*NUM_VC +: NUM_VC], ovc_ptr[k], NUM_VC);
        end
        // first level, one ivc per input port
        for (int i = 0; i < NUM_PORT; i++) begin
            in_win[i] = rr_pick(req_m[i*NUM_VC +: NUM_VC], in_ptr[i], NUM_VC);
            first_dest[i] = '0;
            cand_win[i] = '0;
            if (in_win[i] >= 0) begin
                n = i * NUM_VC + in_win[i];
                first_dest[i] = dest_port_all[n*NUM_PORT_M1 +: NUM_PORT_M1];
                if (cand[n] >= 0) begin
                    cand_win[i][cand[n]] = 1'b1;
                end
            end
        end
        // second level, dest bits regrouped per output port
        for (int o = 0; o < NUM_PORT; o++) begin
            oreq = '0;
            for (j = 0; j < NUM_PORT; j++) begin
                if (j != o) begin
                    oreq[(j < o) ? j : j - 1] = first_dest[j][(o < j) ? o : o - 1];
                end
            end
            exp_any_out[o] = |oreq;
            out_slot[o] = rr_pick(oreq, out_ptr[o], NUM_PORT_M1);
            // slot back to input port, stays -1 when idle
            out_src[o] = (out_slot[o] < o) ? out_slot[o] : out_slot[o] + 1;
            if (out_slot[o] >= 0) begin
                j = out_src[o];
                exp_gdest[j*NUM_PORT_M1 + ((o < j) ? o : o - 1)] = 1'b1;
                exp_alloc[o*NUM_VC +: NUM_VC] = cand_win[j];
            end
        end
        // winning ports keep their ivc and broadcast the candidate
        for (int i = 0; i < NUM_PORT; i++) begin
            exp_any_in[i] = |exp_gdest[i*NUM_PORT_M1 +: NUM_PORT_M1];
            if (exp_any_in[i]) begin
                n = i * NUM_VC + in_win[i];
                exp_sw[n] = 1'b1;
                exp_ovc[n] = |cand_win[i];
                for (int v = 0; v < NUM_VC; v++) begin
                    exp_gnum[(i*NUM_VC + v)*NUM_VC +: NUM_VC] = cand_win[i];
                end
            end
        end
        check_value("granted_dest_port_all", 80'(granted_dest_port_all), 80'(exp_gdest));
        check_value("ivc_num_getting_sw_grant", 80'(ivc_num_getting_sw_grant), 80'(exp_sw));
        check_value("any_ivc_sw_request_granted_all", 80'(any_ivc_sw_request_granted_all),
            80'(exp_any_in));
        check_value("any_ovc_granted_in_outport_all", 80'(any_ovc_granted_in_outport_all),
            80'(exp_any_out));
        check_value("ivc_num_getting_ovc_grant", 80'(ivc_num_getting_ovc_grant), 80'(exp_ovc));
        check_value("granted_ovc_num_all", 80'(granted_ovc_num_all), 80'(exp_gnum));
        check_value("ovc_allocated_all", 80'(ovc_allocated_all), 80'(exp_alloc));
        // pointer moves for the coming rising edge
        for (int i = 0; i < NUM_PORT; i++) begin
            if ((in_win[i] >= 0) && ((EXT_P_EN != 1) || exp_any_in[i])) begin
                in_ptr[i] = (in_win[i] + 1) % NUM_VC;
            end
        end
        for (int o = 0; o < NUM_PORT; o++) begin
            if ((out_slot[o] >= 0) && iport_weight_is_consumed_all[out_src[o]]) begin
                out_ptr[o] = (out_slot[o] + 1) % NUM_PORT_M1;
            end
        end
        for (int k = 0; k < NUM_IVC; k++) begin
            if (exp_ovc[k]) begin
                ovc_ptr[k] = (cand[k] + 1) % NUM_VC;
            end
        end
    endtask

    // outputs settle 1 ns after the falling edge
    task automatic step();
        #1;
        check_and_advance();
    endtask

    task automatic test_single_assigned();
        @(negedge clk);
        clear_inputs();
        add_request(1, 2, 3, 1'b1, 1'b1, '0);
        step();
        assert (ivc_num_getting_sw_grant[1*NUM_VC + 2] && any_ovc_granted_in_outport_all[3])
        else abort_run("single assigned request was not switched to port 3");
    endtask

    task automatic test_full_assigned();
        @(negedge clk);
        clear_inputs();
        add_request(1, 2, 3, 1'b1, 1'b0, '0);
        step();
        assert (ivc_num_getting_sw_grant == '0 && any_ovc_granted_in_outport_all == '0)
        else abort_run("request to a full ovc was still granted");
    endtask

    task automatic test_ovc_rotation();
        vc_mask_t prev;
        vc_mask_t got;
        prev = '0;
        repeat (4) begin
            @(negedge clk);
            clear_inputs();
            add_request(2, 0, 0, 1'b0, 1'b0, 4'b1011);
            step();
            // another ivc of the port sees the same ovc number
            got = granted_ovc_num_all[(2*NUM_VC + 3)*NUM_VC +: NUM_VC];
            assert ($onehot(got) && ((got & ~4'b1011) == '0) && (got != prev))
            else abort_run("ovc allocation did not move on to the next free ovc");
            prev = got;
        end
    endtask

    task automatic test_weighted_output();
        port_mask_t win;
        port_mask_t prev;
        prev = '0;
        for (int c = 0; c < 7; c++) begin
            @(negedge clk);
            clear_inputs();
            add_request(0, 0, 4, 1'b1, 1'b1, '0);
            add_request(1, 0, 4, 1'b1, 1'b1, '0);
            add_request(3, 0, 4, 1'b1, 1'b1, '0);
            // weights used up in the first four cycles only
            iport_weight_is_consumed_all = (c < 4) ? '1 : '0;
            step();
            win = any_ivc_sw_request_granted_all;
            assert ($onehot(win) && ((c < 5) ? (win != prev) : (win == prev)))
            else abort_run("output winner did not follow the weight bits");
            prev = win;
        end
    endtask

    task automatic test_input_ext();
        vc_mask_t last_vc;
        int wins;
        last_vc = '0;
        wins = 0;
        for (int c = 0; c < 9; c++) begin
            @(negedge clk);
            clear_inputs();
            add_request(0, 1, 2, 1'b1, 1'b1, '0);
            add_request(0, 3, 2, 1'b1, 1'b1, '0);
            // port 1 fights for port 2 after three cycles
            if (c >= 3) begin
                add_request(1, 0, 2, 1'b1, 1'b1, '0);
            end
            iport_weight_is_consumed_all = '1;
            step();
            if (any_ivc_sw_request_granted_all[0]) begin
                wins++;
                assert (ivc_num_getting_sw_grant[NUM_VC-1:0] != last_vc)
                else abort_run("input arbiter did not alternate between its two ivcs");
                last_vc = ivc_num_getting_sw_grant[NUM_VC-1:0];
            end
        end
        assert (wins > 3 && wins < 9)
        else abort_run("port 0 never lost its output to port 1");
    endtask

    task automatic test_random();
        logic [31:0] r;
        repeat (N_RAND) begin
            @(negedge clk);
            r = lcg_next();
            ivc_request_all = r[31:12];
            r = lcg_next();
            ovc_is_assigned_all = r[31:12];
            r = lcg_next();
            assigned_ovc_not_full_all = r[31:12];
            iport_weight_is_consumed_all = r[11:7];
            for (int k = 0; k < NUM_IVC; k++) begin
                r = lcg_next();
                // only ivcs without an ovc offer free ones, about half of them
                masked_ovc_request_all[k*NUM_VC +: NUM_VC] =
                    (ovc_is_assigned_all[k] || r[31]) ? '0 : r[19:16];
                dest_port_all[k*NUM_PORT_M1 +: NUM_PORT_M1] = dest_port_t'(1) << r[25:24];
            end
            step();
            for (int i = 0; i < NUM_PORT; i++) begin
                assert ($onehot0(ivc_num_getting_sw_grant[i*NUM_VC +: NUM_VC]))
                else abort_run("more than one ivc of a port got the switch");
            end
            assert ((ivc_num_getting_ovc_grant & ~ivc_num_getting_sw_grant) == '0)
            else abort_run("an ovc grant went to an ivc without a switch grant");
        end
    endtask

    initial begin
        rst = 1'b1;
        clear_inputs();
        repeat (10) @(negedge clk);
        rst = 1'b0;
        // idle cycle straight after reset
        step();
        test_single_assigned();
        test_full_assigned();
        test_ovc_rotation();
        test_weighted_output();
        test_input_ext();
        test_random();
        $display("Result: PASSED");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        abort_run("watchdog timeout, the tests did not finish in time");
    end

endmodule

// File: hdl/comb_nonspec_allocator.sv
`timescale 1ns/10ps

module comb_nonspec_allocator #(
    parameter int FIRST_ARBITER_EXT_P_EN = 1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  noc_alloc_pkg::ivc_mask_t          ivc_request_all,
    input  noc_alloc_pkg::ivc_mask_t          ovc_is_assigned_all,
    input  noc_alloc_pkg::ivc_mask_t          assigned_ovc_not_full_all,
    input  noc_alloc_pkg::ovc_req_all_t       masked_ovc_request_all,
    input  noc_alloc_pkg::dest_port_all_t     dest_port_all,
    input  noc_alloc_pkg::port_mask_t         iport_weight_is_consumed_all,
    output noc_alloc_pkg::granted_dest_all_t  granted_dest_port_all,
    output noc_alloc_pkg::ivc_mask_t          ivc_num_getting_sw_grant,
    output noc_alloc_pkg::port_mask_t         any_ivc_sw_request_granted_all,
    output noc_alloc_pkg::port_mask_t         any_ovc_granted_in_outport_all,
    output noc_alloc_pkg::ivc_mask_t          ivc_num_getting_ovc_grant,
    output noc_alloc_pkg::ovc_req_all_t       granted_ovc_num_all,
    output noc_alloc_pkg::ivc_mask_t          ovc_allocated_all
);

    import noc_alloc_pkg::*;

    ivc_mask_t    ivc_request_masked_all;
    ovc_req_all_t candidate_ovc_all;
    ivc_mask_t    first_arbiter_granted_ivc_all;

    // request masking and per-ivc ovc nomination
    ovc_candidate_select u_cand (
        .clk                      (clk),
        .rst                      (rst),
        .ivc_request_all          (ivc_request_all),
        .ovc_is_assigned_all      (ovc_is_assigned_all),
        .assigned_ovc_not_full_all(assigned_ovc_not_full_all),
        .masked_ovc_request_all   (masked_ovc_request_all),
        .ivc_num_getting_ovc_grant(ivc_num_getting_ovc_grant),
        .ivc_request_masked_all   (ivc_request_masked_all),
        .candidate_ovc_all        (candidate_ovc_all)
    );

    // two-level switch allocation
    nonspec_sw_alloc #(
        .FIRST_ARBITER_EXT_P_EN(FIRST_ARBITER_EXT_P_EN)
    ) u_sw_alloc (
        .clk                          (clk),
        .rst                          (rst),
        .ivc_request_masked_all       (ivc_request_masked_all),
        .dest_port_all                (dest_port_all),
        .iport_weight_is_consumed_all (iport_weight_is_consumed_all),
        .first_arbiter_granted_ivc_all(first_arbiter_granted_ivc_all),
        .ivc_num_getting_sw_grant     (ivc_num_getting_sw_grant),
        .granted_dest_port_all        (granted_dest_port_all),
        .any_ivc_granted_all          (any_ivc_sw_request_granted_all),
        .any_ovc_granted_all          (any_ovc_granted_in_outport_all)
    );

    // switch winners take their candidate ovc
    // grant strobe also feeds back to the ovc arbiters
    ovc_grant_route u_route (
        .candidate_ovc_all            (candidate_ovc_all),
        .first_arbiter_granted_ivc_all(first_arbiter_granted_ivc_all),
        .granted_dest_port_all        (granted_dest_port_all),
        .any_ivc_granted_all          (any_ivc_sw_request_granted_all),
        .granted_ovc_num_all          (granted_ovc_num_all),
        .ivc_num_getting_ovc_grant    (ivc_num_getting_ovc_grant),
        .ovc_allocated_all            (ovc_allocated_all)
    );

endmodule

// File: hdl/ovc_grant_route.sv
`timescale 1ns/10ps

module ovc_grant_route (
    input  noc_alloc_pkg::ovc_req_all_t      candidate_ovc_all,
    input  noc_alloc_pkg::ivc_mask_t         first_arbiter_granted_ivc_all,
    input  noc_alloc_pkg::granted_dest_all_t granted_dest_port_all,
    input  noc_alloc_pkg::port_mask_t        any_ivc_granted_all,
    output noc_alloc_pkg::ovc_req_all_t      granted_ovc_num_all,
    output noc_alloc_pkg::ivc_mask_t         ivc_num_getting_ovc_grant,
    output noc_alloc_pkg::ivc_mask_t         ovc_allocated_all
);

    import noc_alloc_pkg::*;

    // candidate ovc of each port's first-level winner
    vc_mask_t cand_winner [NUM_PORT];
    // set when two inputs land on the same ovc
    logic alloc_collision;

    // one-hot select by the first-level grant
    always_comb begin
        for (int i = 0; i < NUM_PORT; i++) begin
            cand_winner[i] = '0;
            for (int v = 0; v < NUM_VC; v++) begin
                if (first_arbiter_granted_ivc_all[i*NUM_VC + v]) begin
                    cand_winner[i] = cand_winner[i]
                        | candidate_ovc_all[(i*NUM_VC + v)*NUM_VC +: NUM_VC];
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_PORT; i++) begin : g_port
        // ivc flagged only when there is a real ovc to hand over
        assign ivc_num_getting_ovc_grant[i*NUM_VC +: NUM_VC] =
            (any_ivc_granted_all[i] && (|cand_winner[i]))
            ? first_arbiter_granted_ivc_all[i*NUM_VC +: NUM_VC] : '0;

        // same ovc number broadcast to all ivcs of the port
        for (genvar v = 0; v < NUM_VC; v++) begin : g_vc
            assign granted_ovc_num_all[(i*NUM_VC + v)*NUM_VC +: NUM_VC] =
                any_ivc_granted_all[i] ? cand_winner[i] : '0;
        end
    end

    // output side, steer each candidate to the output port it won
    always_comb begin
        ivc_mask_t contrib;
        ovc_allocated_all = '0;
        alloc_collision = 1'b0;
        for (int j = 0; j < NUM_PORT; j++) begin
            contrib = '0;
            for (int k = 0; k < NUM_PORT_M1; k++) begin
                int o;
                // dest bit k back to a router port number
                o = (k < j) ? k : k + 1;
                if (granted_dest_port_all[j*NUM_PORT_M1 + k]) begin
                    contrib[o*NUM_VC +: NUM_VC] = contrib[o*NUM_VC +: NUM_VC] | cand_winner[j];
                end
            end
            alloc_collision = alloc_collision | (|(ovc_allocated_all & contrib));
            ovc_allocated_all = ovc_allocated_all | contrib;
        end
    end

    // one ovc never goes to two inputs in the same cycle
    always_comb begin
        a_ovc_once: assert final (!alloc_collision);
    end

endmodule

// File: hdl/nonspec_sw_alloc.sv
`timescale 1ns/10ps

module nonspec_sw_alloc #(
    parameter int FIRST_ARBITER_EXT_P_EN = 1
) (
    input  logic                             clk,
    input  logic                             rst,
    input  noc_alloc_pkg::ivc_mask_t          ivc_request_masked_all,
    input  noc_alloc_pkg::dest_port_all_t     dest_port_all,
    input  noc_alloc_pkg::port_mask_t         iport_weight_is_consumed_all,
    output noc_alloc_pkg::ivc_mask_t          first_arbiter_granted_ivc_all,
    output noc_alloc_pkg::ivc_mask_t          ivc_num_getting_sw_grant,
    output noc_alloc_pkg::granted_dest_all_t  granted_dest_port_all,
    output noc_alloc_pkg::port_mask_t         any_ivc_granted_all,
    output noc_alloc_pkg::port_mask_t         any_ovc_granted_all
);

    import noc_alloc_pkg::*;

    // input side, per input port
    port_mask_t in_any_grant;
    port_mask_t in_update;
    dest_port_t first_dest [NUM_PORT];

    // output side, per output port, indexed in its own P-1 code
    dest_port_t out_request [NUM_PORT];
    dest_port_t out_grant [NUM_PORT];
    dest_port_t out_weight [NUM_PORT];
    port_mask_t out_update;

    // output grants seen as plain input-port masks
    port_mask_t out_col [NUM_PORT];

    // destination of each first-level winner
    always_comb begin
        for (int i = 0; i < NUM_PORT; i++) begin
            first_dest[i] = '0;
            for (int v = 0; v < NUM_VC; v++) begin
                if (first_arbiter_granted_ivc_all[i*NUM_VC + v]) begin
                    first_dest[i] = first_dest[i]
                        | dest_port_all[(i*NUM_VC + v)*NUM_PORT_M1 +: NUM_PORT_M1];
                end
            end
        end
    end

    for (genvar i = 0; i < NUM_PORT; i++) begin : g_in
        // ext mode: priority moves only when the whole port wins
        assign in_update[i] = (FIRST_ARBITER_EXT_P_EN == 1) ? any_ivc_granted_all[i]
                                                           : in_any_grant[i];

        // first level, one ivc per input port
        rr_arbiter #(
            .ARBITER_WIDTH(NUM_VC)
        ) u_in_arb (
            .clk      (clk),
            .rst      (rst),
            .request  (ivc_request_masked_all[i*NUM_VC +: NUM_VC]),
            .update   (in_update[i]),
            .grant    (first_arbiter_granted_ivc_all[i*NUM_VC +: NUM_VC]),
            .any_grant(in_any_grant[i])
        );

        assign any_ivc_granted_all[i] = |granted_dest_port_all[i*NUM_PORT_M1 +: NUM_PORT_M1];

        // first-level grant only survives if the port won its output
        assign ivc_num_getting_sw_grant[i*NUM_VC +: NUM_VC] = any_ivc_granted_all[i]
            ? first_arbiter_granted_ivc_all[i*NUM_VC +: NUM_VC] : '0;
    end

    for (genvar o = 0; o < NUM_PORT; o++) begin : g_out
        for (genvar j = 0; j < NUM_PORT; j++) begin : g_link
            if (j != o) begin : g_cross
                // slot of input j at output o
                localparam int OI = (j < o) ? j : j - 1;
                // slot of output o in input j's dest code
                localparam int DI = (o < j) ? o : o - 1;

                // transpose dest into output requests and grants back
                assign out_request[o][OI] = first_dest[j][DI];
                assign out_weight[o][OI] = iport_weight_is_consumed_all[j];
                assign granted_dest_port_all[j*NUM_PORT_M1 + DI] = out_grant[o][OI];
                assign out_col[o][j] = granted_dest_port_all[j*NUM_PORT_M1 + DI];
            end else begin : g_self
                assign out_col[o][j] = 1'b0;
            end
        end

        // weighted: pointer moves once the winner's weight is used up
        assign out_update[o] = |(out_grant[o] & out_weight[o]);

        // second level, one input port per output port
        rr_arbiter #(
            .ARBITER_WIDTH(NUM_PORT_M1)
        ) u_out_arb (
            .clk      (clk),
            .rst      (rst),
            .request  (out_request[o]),
            .update   (out_update[o]),
            .grant    (out_grant[o]),
            .any_grant(any_ovc_granted_all[o])
        );

        // at most one input port drives this output
        a_out_single: assert property (@(posedge clk) disable iff (rst) $onehot0(out_col[o]));
    end

    for (genvar i = 0; i < NUM_PORT; i++) begin : g_chk
        // own port has no code bit, so a granted dest must be the one asked for
        a_in_dest_ok: assert property (@(posedge clk) disable iff (rst)
            $onehot0(granted_dest_port_all[i*NUM_PORT_M1 +: NUM_PORT_M1])
            && ((granted_dest_port_all[i*NUM_PORT_M1 +: NUM_PORT_M1] & ~first_dest[i]) == '0));
    end

endmodule

// File: hdl/ovc_candidate_select.sv
`timescale 1ns/10ps

module ovc_candidate_select (
    input  logic                      clk,
    input  logic                      rst,
    input  noc_alloc_pkg::ivc_mask_t    ivc_request_all,
    input  noc_alloc_pkg::ivc_mask_t    ovc_is_assigned_all,
    input  noc_alloc_pkg::ivc_mask_t    assigned_ovc_not_full_all,
    input  noc_alloc_pkg::ovc_req_all_t masked_ovc_request_all,
    input  noc_alloc_pkg::ivc_mask_t    ivc_num_getting_ovc_grant,
    output noc_alloc_pkg::ivc_mask_t    ivc_request_masked_all,
    output noc_alloc_pkg::ovc_req_all_t candidate_ovc_all
);

    import noc_alloc_pkg::*;

    // ivcs that already own an ovc with room in it
    ivc_mask_t assigned_req_ok;

    // full ovc drops the request this cycle
    assign assigned_req_ok = ivc_request_all & ovc_is_assigned_all & assigned_ovc_not_full_all;

    for (genvar i = 0; i < NUM_IVC; i++) begin : g_ivc
        // free ovcs this ivc could take
        vc_mask_t free_ovc;

        assign free_ovc = masked_ovc_request_all[i*NUM_VC +: NUM_VC];

        // switch request from either an owned ovc or a free one
        assign ivc_request_masked_all[i] = assigned_req_ok[i] | (|free_ovc);

        // nominate one free ovc
        // pointer moves only when the ivc really gets its ovc
        rr_arbiter #(
            .ARBITER_WIDTH(NUM_VC)
        ) u_ovc_arb (
            .clk      (clk),
            .rst      (rst),
            .request  (free_ovc),
            .update   (ivc_num_getting_ovc_grant[i]),
            .grant    (candidate_ovc_all[i*NUM_VC +: NUM_VC]),
            .any_grant()
        );
    end

endmodule

// File: hdl/rr_arbiter.sv
`timescale 1ns/10ps

module rr_arbiter #(
    parameter int ARBITER_WIDTH = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [ARBITER_WIDTH-1:0] request,
    input  logic                     update,
    output logic [ARBITER_WIDTH-1:0] grant,
    output logic                     any_grant
);

    localparam int PTR_W = (ARBITER_WIDTH > 1) ? $clog2(ARBITER_WIDTH) : 1;

    // index with the highest priority this cycle
    logic [PTR_W-1:0] pointer;
    // index of the current winner
    logic [PTR_W-1:0] grant_idx;
    logic [PTR_W-1:0] next_pointer;

    // scan upward from the pointer, wrapping at the top
    always_comb begin
        logic found;
        found = 1'b0;
        grant = '0;
        grant_idx = '0;
        for (int off = 0; off < ARBITER_WIDTH; off++) begin
            int idx;
            idx = int'(pointer) + off;
            if (idx >= ARBITER_WIDTH) begin
                idx = idx - ARBITER_WIDTH;
            end
            // first requester met wins
            if (!found && request[idx]) begin
                found = 1'b1;
                grant[idx] = 1'b1;
                grant_idx = PTR_W'(idx);
            end
        end
    end

    assign any_grant = |request;

    // winner drops to lowest priority
    assign next_pointer = (grant_idx == PTR_W'(ARBITER_WIDTH - 1)) ? '0 : grant_idx + 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            pointer <= '0;
        end else if (update && any_grant) begin
            pointer <= next_pointer;
        end
    end

    // single winner per cycle
    a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

    // never grant an idle requester
    a_grant_in_request: assert property (@(posedge clk) disable iff (rst)
        (grant & ~request) == '0);

endmodule

// File: hdl/noc_alloc_pkg.sv
package noc_alloc_pkg;

    // router geometry
    // vcs per port
    localparam int NUM_VC = 4;
    // ports of one router
    localparam int NUM_PORT = 5;
    // a port never routes back to itself
    localparam int NUM_PORT_M1 = NUM_PORT - 1;
    // all input vcs, index is port * NUM_VC + vc
    localparam int NUM_IVC = NUM_VC * NUM_PORT;

    // one bit per vc of a single port
    typedef logic [NUM_VC-1:0] vc_mask_t;

    // one bit per router port
    typedef logic [NUM_PORT-1:0] port_mask_t;

    // one-hot destination among the other ports
    // for port i, bit k is port k below i and port k+1 from i upward
    typedef logic [NUM_PORT_M1-1:0] dest_port_t;

    // one bit per ivc of the router
    typedef logic [NUM_IVC-1:0] ivc_mask_t;

    // per ivc, the ovcs it may take (or the ovc it got)
    typedef logic [NUM_IVC*NUM_VC-1:0] ovc_req_all_t;

    // per ivc, its one-hot destination
    typedef logic [NUM_IVC*NUM_PORT_M1-1:0] dest_port_all_t;

    // per input port, the destination it won
    typedef logic [NUM_PORT*NUM_PORT_M1-1:0] granted_dest_all_t;

endpackage
